//--- filelist.f
vlsu_pkg.sv
vlsu_issue.sv
vlsu_lane.sv
vlsu_writeback.sv
vlsu_top.sv
tb_clock_gen.sv
tb_vlsu_models.sv
tb_vlsu.sv

//--- Makefile
# Verilator build and run of the vector load/store unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_vlsu
RTL_TOP    ?= vlsu_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= vlsu_pkg.sv vlsu_issue.sv vlsu_lane.sv vlsu_writeback.sv vlsu_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_vlsu.sv
/* Testbench for the vector load/store unit with two memory lanes
   Every instruction is checked against the complete memory and register images
   The first suite runs with the models always ready and the second under random stalls */

`timescale 1ns/1ps
`default_nettype none

module tb_vlsu;

  import vlsu_pkg::*;

  localparam int unsigned NrPorts  = 2;
  localparam int unsigned NumTests = 16;
  localparam int unsigned MemWords = 1024;
  localparam int unsigned VrfWords = 256;

  logic                       clk;
  logic                       rst_n;
  logic                       stress;
  vlsu_req_t                  spatz_req;
  logic                       spatz_req_valid;
  logic                       spatz_req_ready;
  logic                       vlsu_rsp_valid;
  vlsu_rsp_t                  vlsu_rsp;
  logic                       x_mem_finished;
  logic                       vrf_we;
  vreg_addr_t                 vrf_waddr;
  elen_t        [NrPorts-1:0] vrf_wdata;
  strb_t        [NrPorts-1:0] vrf_wbe;
  logic                       vrf_wvalid;
  logic                       vrf_re;
  vreg_addr_t                 vrf_raddr;
  elen_t        [NrPorts-1:0] vrf_rdata;
  logic                       vrf_rvalid;
  logic         [NrPorts-1:0] x_mem_valid;
  mem_req_t     [NrPorts-1:0] x_mem_req;
  logic         [NrPorts-1:0] x_mem_ready;
  logic         [NrPorts-1:0] x_mem_result_valid;
  elen_t        [NrPorts-1:0] x_mem_result;
  int unsigned                checks;
  int unsigned                errors;
  elen_t                      exp_mem [MemWords];
  elen_t        [NrPorts-1:0] exp_vrf [VrfWords];
  vew_e                       cur_vsew;
  int unsigned                cur_total;
  addr_t                      cur_base;

  tb_clock_gen clock_gen_i (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  vlsu_top #(
    .NrPorts  (NrPorts),
    .FifoDepth(4)
  ) vlsu_top_i (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .spatz_req_i         (spatz_req),
    .spatz_req_valid_i   (spatz_req_valid),
    .spatz_req_ready_o   (spatz_req_ready),
    .vlsu_rsp_valid_o    (vlsu_rsp_valid),
    .vlsu_rsp_o          (vlsu_rsp),
    .x_mem_finished_o    (x_mem_finished),
    .vrf_we_o            (vrf_we),
    .vrf_waddr_o         (vrf_waddr),
    .vrf_wdata_o         (vrf_wdata),
    .vrf_wbe_o           (vrf_wbe),
    .vrf_wvalid_i        (vrf_wvalid),
    .vrf_re_o            (vrf_re),
    .vrf_raddr_o         (vrf_raddr),
    .vrf_rdata_i         (vrf_rdata),
    .vrf_rvalid_i        (vrf_rvalid),
    .x_mem_valid_o       (x_mem_valid),
    .x_mem_req_o         (x_mem_req),
    .x_mem_ready_i       (x_mem_ready),
    .x_mem_result_valid_i(x_mem_result_valid),
    .x_mem_result_i      (x_mem_result)
  );

  tb_vlsu_models #(
    .NrPorts(NrPorts)
  ) models_i (
    .clk_i               (clk),
    .stress_i            (stress),
    .x_mem_valid_i       (x_mem_valid),
    .x_mem_req_i         (x_mem_req),
    .x_mem_ready_o       (x_mem_ready),
    .x_mem_result_valid_o(x_mem_result_valid),
    .x_mem_result_o      (x_mem_result),
    .vrf_we_i            (vrf_we),
    .vrf_waddr_i         (vrf_waddr),
    .vrf_wdata_i         (vrf_wdata),
    .vrf_wbe_i           (vrf_wbe),
    .vrf_wvalid_o        (vrf_wvalid),
    .vrf_re_i            (vrf_re),
    .vrf_raddr_i         (vrf_raddr),
    .vrf_rdata_o         (vrf_rdata),
    .vrf_rvalid_o        (vrf_rvalid)
  );

  ////////////////////
  // Reference and checks
  ////////////////////

  // Bytes of a slot that lie below the total byte count come from the source
  function automatic elen_t ref_slot(elen_t old_w, elen_t src_w, int unsigned off,
                                     int unsigned total);
    elen_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (off + b < total) res[8*b +: 8] = src_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("error %s: got 0x%0h expected 0x%0h", name, got, expected);
    end
  endtask

  // Expected images after one instruction
  // One vector register holds 8*NrPorts slots
  task automatic predict(input logic is_load, input vew_e vsew, input int unsigned vl,
                         input int unsigned vd, input addr_t rs1);
    int unsigned total;
    int unsigned w;
    int unsigned s;
    int unsigned m;
    total = vl << vsew;
    for (int i = 0; i < MemWords; i++) exp_mem[i] = models_i.mem[i];
    for (int i = 0; i < VrfWords; i++) exp_vrf[i] = models_i.vrf[i];
    for (int j = 0; j < 8 * NrPorts; j++) begin
      w = vd * 8 + j / NrPorts;
      s = j % NrPorts;
      m = ((rs1 >> 2) + j) % MemWords;
      if (is_load) begin
        exp_vrf[w][s] = ref_slot(exp_vrf[w][s], exp_mem[m], 4 * j, total);
      end else begin
        exp_mem[m] = ref_slot(exp_mem[m], exp_vrf[w][s], 4 * j, total);
      end
    end
  endtask

  // A lane's final request is the one whose next slot of that lane holds no byte
  always @(negedge clk) begin
    int unsigned slot;
    logic        exp_last;
    for (int p = 0; p < NrPorts; p++) begin
      if (x_mem_valid[p] && x_mem_ready[p]) begin
        slot     = (x_mem_req[p].addr - cur_base) >> 2;
        exp_last = ((slot + NrPorts) * 4 >= cur_total);
        check_value($sformatf("x_mem_req[%0d].size", p), 64'(x_mem_req[p].size),
                    64'(cur_vsew));
        check_value($sformatf("x_mem_req[%0d].last", p), 64'(x_mem_req[p].last),
                    64'(exp_last));
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic run_insn(input insn_id_t id, input logic is_load, input vew_e vsew,
                          input int unsigned vl, input int unsigned vd, input addr_t rs1);
    int unsigned cycles;
    logic        traffic;
    logic        early_ready;
    @(posedge clk);
    #1;
    predict(is_load, vsew, vl, vd, rs1);
    cur_vsew  = vsew;
    cur_total = vl << vsew;
    cur_base  = rs1;
    spatz_req = '{id: id, is_load: is_load, vsew: vsew, vl: vlen_t'(vl),
                  vd: vreg_id_t'(vd), rs1: rs1};
    spatz_req_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!spatz_req_ready);
    @(posedge clk);
    #1;
    spatz_req_valid = 1'b0;
    cycles      = 0;
    traffic     = 1'b0;
    early_ready = 1'b0;
    // Counted from the sample point of the accepting edge
    do begin
      @(negedge clk);
      cycles++;
      traffic     = traffic | (|x_mem_valid) | vrf_we | vrf_re;
      early_ready = early_ready | spatz_req_ready;
    end while (!vlsu_rsp_valid);
    check_value("vlsu_rsp.id", 64'(vlsu_rsp.id), 64'(id));
    check_value("vlsu_rsp.vd", 64'(vlsu_rsp.vd), 64'(vd));
    check_value("x_mem_finished", 64'(x_mem_finished), 64'd1);
    if (early_ready) begin
      errors++;
      $display("Request ready rose before the completion pulse of id %0d", id);
    end
    if (vl == 0) begin
      check_value("cycles to completion", 64'(cycles), 64'd2);
      if (traffic) begin
        errors++;
        $display("Memory or register traffic seen for a zero length request");
      end
    end
    @(negedge clk);
    check_value("vlsu_rsp_valid", 64'(vlsu_rsp_valid), 64'd0);
    check_value("x_mem_finished", 64'(x_mem_finished), 64'd0);
    check_value("spatz_req_ready", 64'(spatz_req_ready), 64'd1);
    @(posedge clk);
    #1;
    for (int i = 0; i < MemWords; i++) begin
      check_value($sformatf("mem[0x%0h]", 4 * i), 64'(models_i.mem[i]), 64'(exp_mem[i]));
    end
    for (int i = 0; i < VrfWords; i++) begin
      check_value($sformatf("vrf[0x%0h]", i), 64'(models_i.vrf[i]), 64'(exp_vrf[i]));
    end
  endtask

  // Full load, partial loads, partial stores and zero length requests
  task automatic run_suite(input insn_id_t id0, input int unsigned vd0, input addr_t base);
    run_insn(id0,          1'b1, EW_32, 16, vd0,     base);
    run_insn(id0 + 3'd1,   1'b1, EW_8,  13, vd0 + 1, base + 32'h080);
    run_insn(id0 + 3'd2,   1'b1, EW_16, 5,  vd0 + 2, base + 32'h100);
    run_insn(id0 + 3'd3,   1'b0, EW_32, 5,  vd0 + 3, base + 32'h180);
    run_insn(id0 + 3'd4,   1'b0, EW_8,  11, vd0 + 4, base + 32'h1C0);
    run_insn(id0 + 3'd5,   1'b0, EW_16, 9,  vd0 + 5, base + 32'h200);
    run_insn(id0 + 3'd6,   1'b1, EW_8,  0,  vd0 + 6, base + 32'h240);
    run_insn(id0 + 3'd7,   1'b0, EW_32, 0,  vd0 + 7, base + 32'h280);
  endtask

  initial begin
    void'($urandom(26875));
    checks          = 0;
    errors          = 0;
    stress          = 1'b0;
    cur_vsew        = EW_8;
    cur_total       = 0;
    cur_base        = '0;
    spatz_req       = '0;
    spatz_req_valid = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    check_value("spatz_req_ready", 64'(spatz_req_ready), 64'd1);
    check_value("x_mem_valid", 64'(x_mem_valid), 64'd0);
    check_value("vrf_we", 64'(vrf_we), 64'd0);
    check_value("vrf_re", 64'(vrf_re), 64'd0);
    check_value("vlsu_rsp_valid", 64'(vlsu_rsp_valid), 64'd0);
    check_value("x_mem_finished", 64'(x_mem_finished), 64'd0);
    run_suite(3'd1, 1, 32'h000);
    stress = 1'b1;
    run_suite(3'd5, 10, 32'h400);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (NumTests * 2000) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", NumTests * 2000);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_vlsu_models.sv
/* Memory and register file models for the load/store testbench
   Memory holds 1024 words and wraps at 4 KiB, results return in order per port
   With stress_i low every handshake is ready and every latency is one cycle */

`timescale 1ns/1ps
`default_nettype none

module tb_vlsu_models #(
  parameter int unsigned NrPorts = 2
) (
  input  logic                                clk_i,
  input  logic                                stress_i,
  input  logic                  [NrPorts-1:0] x_mem_valid_i,
  input  vlsu_pkg::mem_req_t    [NrPorts-1:0] x_mem_req_i,
  output logic                  [NrPorts-1:0] x_mem_ready_o,
  output logic                  [NrPorts-1:0] x_mem_result_valid_o,
  output vlsu_pkg::elen_t       [NrPorts-1:0] x_mem_result_o,
  input  logic                                vrf_we_i,
  input  vlsu_pkg::vreg_addr_t                vrf_waddr_i,
  input  vlsu_pkg::elen_t       [NrPorts-1:0] vrf_wdata_i,
  input  vlsu_pkg::strb_t       [NrPorts-1:0] vrf_wbe_i,
  output logic                                vrf_wvalid_o,
  input  logic                                vrf_re_i,
  input  vlsu_pkg::vreg_addr_t                vrf_raddr_i,
  output vlsu_pkg::elen_t       [NrPorts-1:0] vrf_rdata_o,
  output logic                                vrf_rvalid_o
);

  import vlsu_pkg::*;

  localparam int unsigned MemWords = 1024;
  localparam int unsigned VrfWords = 256;
  localparam int unsigned RingSize = 8;

  elen_t                mem [MemWords];
  elen_t  [NrPorts-1:0] vrf [VrfWords];
  elen_t                ring_data [NrPorts][RingSize];
  int unsigned          ring_due [NrPorts][RingSize];
  int unsigned          ring_wr [NrPorts];
  int unsigned          ring_rd [NrPorts];
  int unsigned          ring_cnt [NrPorts];
  int unsigned          lat [NrPorts];
  int unsigned          cyc;
  int unsigned          rd_due;
  logic                 rd_pend;
  elen_t  [NrPorts-1:0] rd_word;
  logic   [9:0]         widx;

  initial begin
    // Fill patterns mix every address bit
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = (32'(i) * 32'h0104_0811) ^ 32'h5A3C_0000 ^ (32'(i) << 2);
    end
    for (int i = 0; i < VrfWords; i++) begin
      for (int p = 0; p < NrPorts; p++) begin
        vrf[i][p] = 32'hC000_0000 ^ (32'(i) << 12) ^ (32'(p) << 8) ^ (32'(i) * 32'h0001_0003);
      end
    end
    for (int p = 0; p < NrPorts; p++) begin
      ring_wr[p]  = 0;
      ring_rd[p]  = 0;
      ring_cnt[p] = 0;
      lat[p]      = 1;
    end
    cyc                  = 0;
    rd_pend              = 1'b0;
    rd_due               = 0;
    rd_word              = '0;
    x_mem_ready_o        = '0;
    x_mem_result_valid_o = '0;
    x_mem_result_o       = '0;
    vrf_wvalid_o         = 1'b0;
    vrf_rdata_o          = '0;
    vrf_rvalid_o         = 1'b0;
  end

  ////////////////////
  // Transfers, sampled mid-cycle where all signals are settled
  ////////////////////

  always @(negedge clk_i) begin
    for (int p = 0; p < NrPorts; p++) begin
      if (x_mem_valid_i[p] && x_mem_ready_o[p]) begin
        widx = x_mem_req_i[p].addr[11:2];
        if (x_mem_req_i[p].we) begin
          for (int b = 0; b < ELENB; b++) begin
            if (x_mem_req_i[p].strb[b]) mem[widx][8*b +: 8] = x_mem_req_i[p].wdata[8*b +: 8];
          end
        end else begin
          ring_data[p][ring_wr[p]] = mem[widx];
          ring_due[p][ring_wr[p]]  = cyc + lat[p];
          ring_wr[p]               = (ring_wr[p] + 1) % RingSize;
          ring_cnt[p]++;
        end
      end
    end
    if (vrf_we_i && vrf_wvalid_o) begin
      for (int p = 0; p < NrPorts; p++) begin
        for (int b = 0; b < ELENB; b++) begin
          if (vrf_wbe_i[p][b]) vrf[vrf_waddr_i][p][8*b +: 8] = vrf_wdata_i[p][8*b +: 8];
        end
      end
    end
    if (vrf_re_i) begin
      rd_pend = 1'b1;
      rd_word = vrf[vrf_raddr_i];
      rd_due  = cyc + lat[0];
    end
  end

  ////////////////////
  // Responses, driven 1 ns after the edge
  ////////////////////

  always @(posedge clk_i) begin
    cyc++;
    #1;
    for (int p = 0; p < NrPorts; p++) begin
      x_mem_ready_o[p]        = stress_i ? ($urandom_range(3) != 0) : 1'b1;
      lat[p]                  = stress_i ? $urandom_range(5, 1) : 1;
      x_mem_result_valid_o[p] = 1'b0;
      if (ring_cnt[p] != 0 && cyc >= ring_due[p][ring_rd[p]]) begin
        x_mem_result_valid_o[p] = 1'b1;
        x_mem_result_o[p]       = ring_data[p][ring_rd[p]];
        ring_rd[p]              = (ring_rd[p] + 1) % RingSize;
        ring_cnt[p]--;
      end
    end
    vrf_wvalid_o = stress_i ? ($urandom_range(2) != 0) : 1'b1;
    vrf_rvalid_o = 1'b0;
    if (rd_pend && cyc >= rd_due) begin
      vrf_rvalid_o = 1'b1;
      vrf_rdata_o  = rd_word;
      rd_pend      = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/* Testbench clock of 4 ns period and an active low reset
   Reset is released 1 ns after the eighth rising edge */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned HalfPeriod  = 2,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- vlsu_top.sv
/* Vector load/store unit top, NrPorts must be a power of two
   Register words are NrPorts slots wide, one memory port per slot */

`timescale 1ns/1ps
`default_nettype none

module vlsu_top #(
  parameter int unsigned NrPorts   = 2,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  vlsu_pkg::vlsu_req_t                 spatz_req_i,
  input  logic                                spatz_req_valid_i,
  output logic                                spatz_req_ready_o,
  output logic                                vlsu_rsp_valid_o,
  output vlsu_pkg::vlsu_rsp_t                 vlsu_rsp_o,
  output logic                                x_mem_finished_o,
  output logic                                vrf_we_o,
  output vlsu_pkg::vreg_addr_t                vrf_waddr_o,
  output vlsu_pkg::elen_t       [NrPorts-1:0] vrf_wdata_o,
  output vlsu_pkg::strb_t       [NrPorts-1:0] vrf_wbe_o,
  input  logic                                vrf_wvalid_i,
  output logic                                vrf_re_o,
  output vlsu_pkg::vreg_addr_t                vrf_raddr_o,
  input  vlsu_pkg::elen_t       [NrPorts-1:0] vrf_rdata_i,
  input  logic                                vrf_rvalid_i,
  output logic                  [NrPorts-1:0] x_mem_valid_o,
  output vlsu_pkg::mem_req_t    [NrPorts-1:0] x_mem_req_o,
  input  logic                  [NrPorts-1:0] x_mem_ready_i,
  input  logic                  [NrPorts-1:0] x_mem_result_valid_i,
  input  vlsu_pkg::elen_t       [NrPorts-1:0] x_mem_result_i
);

  import vlsu_pkg::*;

  vlsu_cmd_t                  cmd;
  logic                       cmd_start;
  logic                       st_push;
  elen_t        [NrPorts-1:0] st_data;
  logic         [NrPorts-1:0] lane_st_space;
  logic         [NrPorts-1:0] lane_drained;
  lane_entry_t  [NrPorts-1:0] lane_head;
  logic         [NrPorts-1:0] lane_head_valid;
  logic         [NrPorts-1:0] lane_pop;
  logic                       wb_idle;

  vlsu_issue #(
    .NrPorts(NrPorts)
  ) vlsu_issue_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .spatz_req_i      (spatz_req_i),
    .spatz_req_valid_i(spatz_req_valid_i),
    .spatz_req_ready_o(spatz_req_ready_o),
    .cmd_o            (cmd),
    .cmd_start_o      (cmd_start),
    .lane_st_space_i  (lane_st_space),
    .lane_drained_i   (lane_drained),
    .wb_idle_i        (wb_idle),
    .st_push_o        (st_push),
    .st_data_o        (st_data),
    .vrf_re_o         (vrf_re_o),
    .vrf_raddr_o      (vrf_raddr_o),
    .vrf_rdata_i      (vrf_rdata_i),
    .vrf_rvalid_i     (vrf_rvalid_i),
    .vlsu_rsp_valid_o (vlsu_rsp_valid_o),
    .vlsu_rsp_o       (vlsu_rsp_o),
    .x_mem_finished_o (x_mem_finished_o)
  );

  for (genvar p = 0; p < NrPorts; p++) begin : gen_lane
    vlsu_lane #(
      .NrPorts  (NrPorts),
      .FifoDepth(FifoDepth),
      .LaneIdx  (p)
    ) vlsu_lane_i (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .cmd_i               (cmd),
      .cmd_start_i         (cmd_start),
      .st_push_i           (st_push),
      .st_data_i           (st_data[p]),
      .pop_i               (lane_pop[p]),
      .x_mem_valid_o       (x_mem_valid_o[p]),
      .x_mem_req_o         (x_mem_req_o[p]),
      .x_mem_ready_i       (x_mem_ready_i[p]),
      .x_mem_result_valid_i(x_mem_result_valid_i[p]),
      .x_mem_result_i      (x_mem_result_i[p]),
      .head_o              (lane_head[p]),
      .head_valid_o        (lane_head_valid[p]),
      .st_space_o          (lane_st_space[p]),
      .drained_o           (lane_drained[p])
    );
  end

  vlsu_writeback #(
    .NrPorts(NrPorts)
  ) vlsu_writeback_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_i         (cmd),
    .cmd_start_i   (cmd_start),
    .head_i        (lane_head),
    .head_valid_i  (lane_head_valid),
    .lane_drained_i(lane_drained),
    .pop_o         (lane_pop),
    .vrf_we_o      (vrf_we_o),
    .vrf_waddr_o   (vrf_waddr_o),
    .vrf_wdata_o   (vrf_wdata_o),
    .vrf_wbe_o     (vrf_wbe_o),
    .vrf_wvalid_i  (vrf_wvalid_i),
    .wb_idle_o     (wb_idle)
  );

endmodule

`default_nettype wire

//--- vlsu_writeback.sv
/* Load write-back, merges one FIFO head per lane into a register word
   A write is held until vrf_wvalid_i, a new one may follow in that cycle
   Lanes that are drained get a zero byte enable */

`timescale 1ns/1ps
`default_nettype none

module vlsu_writeback #(
  parameter int unsigned NrPorts = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  vlsu_pkg::vlsu_cmd_t                  cmd_i,
  input  logic                                 cmd_start_i,
  input  vlsu_pkg::lane_entry_t  [NrPorts-1:0] head_i,
  input  logic                   [NrPorts-1:0] head_valid_i,
  input  logic                   [NrPorts-1:0] lane_drained_i,
  output logic                   [NrPorts-1:0] pop_o,
  output logic                                 vrf_we_o,
  output vlsu_pkg::vreg_addr_t                 vrf_waddr_o,
  output vlsu_pkg::elen_t        [NrPorts-1:0] vrf_wdata_o,
  output vlsu_pkg::strb_t        [NrPorts-1:0] vrf_wbe_o,
  input  logic                                 vrf_wvalid_i,
  output logic                                 wb_idle_o
);

  import vlsu_pkg::*;

  logic                we_q;
  vreg_addr_t          word_q;
  vreg_addr_t          waddr_q;
  elen_t [NrPorts-1:0] wdata_q;
  strb_t [NrPorts-1:0] wbe_q;
  logic                slot_free;
  logic                merge;

  // Output register is free when empty or acknowledged this cycle
  assign slot_free = !we_q || vrf_wvalid_i;

  // Every lane has a result or has nothing left to deliver
  assign merge = cmd_i.is_load && slot_free && (|head_valid_i) &&
                 (&(head_valid_i | lane_drained_i));

  assign pop_o = merge ? head_valid_i : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      we_q   <= 1'b0;
      word_q <= '0;
    end else begin
      if (cmd_start_i) begin
        word_q <= '0;
      end else if (merge) begin
        word_q <= word_q + 1'b1;
      end
      if (merge) begin
        we_q <= 1'b1;
      end else if (vrf_wvalid_i) begin
        we_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (merge) begin
      waddr_q <= (vreg_addr_t'(cmd_i.vd) << VregWordsLog2) + word_q;
      for (int p = 0; p < NrPorts; p++) begin
        wdata_q[p] <= head_i[p].data;
        wbe_q[p]   <= head_valid_i[p] ? head_i[p].strb : '0;
      end
    end
  end

  assign vrf_we_o    = we_q;
  assign vrf_waddr_o = waddr_q;
  assign vrf_wdata_o = wdata_q;
  assign vrf_wbe_o   = wbe_q;
  assign wb_idle_o   = !we_q;

endmodule

`default_nettype wire

//--- vlsu_lane.sv
/* One memory lane, owns slot LaneIdx of every register word
   Memory results must come back in request order
   Loads are issued only while a FIFO entry is free for the result */

`timescale 1ns/1ps
`default_nettype none

module vlsu_lane #(
  parameter int unsigned NrPorts   = 2,
  parameter int unsigned FifoDepth = 4,
  parameter int unsigned LaneIdx   = 0
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  vlsu_pkg::vlsu_cmd_t   cmd_i,
  input  logic                  cmd_start_i,
  input  logic                  st_push_i,
  input  vlsu_pkg::elen_t       st_data_i,
  input  logic                  pop_i,
  output logic                  x_mem_valid_o,
  output vlsu_pkg::mem_req_t    x_mem_req_o,
  input  logic                  x_mem_ready_i,
  input  logic                  x_mem_result_valid_i,
  input  vlsu_pkg::elen_t       x_mem_result_i,
  output vlsu_pkg::lane_entry_t head_o,
  output logic                  head_valid_o,
  output logic                  st_space_o,
  output logic                  drained_o
);

  import vlsu_pkg::*;

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  // Byte offset of this lane's slot in word k
  function automatic addr_t slot_offset(vlen_t word);
    return addr_t'((32'(word) * NrPorts + LaneIdx) * ELENB);
  endfunction

  // Bytes of the slot that fall below the total, 0 to 4
  function automatic logic [2:0] slot_bytes(vlen_t total, vlen_t word);
    addr_t off;
    addr_t left;
    off  = slot_offset(word);
    left = (32'(total) > off) ? 32'(total) - off : '0;
    return (left > ELENB) ? 3'(ELENB) : left[2:0];
  endfunction

  function automatic ptr_t next_ptr(ptr_t p);
    return (32'(p) == FifoDepth - 1) ? '0 : p + 1'b1;
  endfunction

  lane_entry_t fifo_q [FifoDepth];
  ptr_t        rd_ptr_q, wr_ptr_q, res_ptr_q;
  cnt_t        fill_q, credit_q;
  vlen_t       word_q;
  logic [2:0]  cur_bytes, next_bytes;
  strb_t       cur_strb;
  logic        active, room;
  logic        req_fire, res_fire, ld_fire;
  logic        push, pop, st_drop;

  assign cur_bytes  = slot_bytes(cmd_i.bytes, word_q);
  assign next_bytes = slot_bytes(cmd_i.bytes, word_q + 1'b1);
  assign active     = (cur_bytes != '0);

  always_comb begin
    for (int b = 0; b < ELENB; b++) begin
      cur_strb[b] = (b < cur_bytes);
    end
  end

  // Outstanding loads plus queued results never exceed the FIFO
  assign room = (32'(fill_q) + 32'(credit_q)) < FifoDepth;

  ////////////////////
  // Memory request
  ////////////////////

  assign x_mem_valid_o = active && (cmd_i.is_load ? room : (fill_q != '0));
  assign req_fire      = x_mem_valid_o && x_mem_ready_i;
  assign ld_fire       = req_fire && cmd_i.is_load;
  assign res_fire      = x_mem_result_valid_i && (credit_q != '0);

  always_comb begin
    x_mem_req_o.addr  = cmd_i.base + slot_offset(word_q);
    x_mem_req_o.we    = !cmd_i.is_load;
    x_mem_req_o.size  = cmd_i.vsew;
    x_mem_req_o.strb  = cur_strb;
    x_mem_req_o.wdata = cmd_i.is_load ? '0 : fifo_q[rd_ptr_q].data;
    x_mem_req_o.last  = (next_bytes == '0);
  end

  // Padding slots of a short last store word are dropped
  assign st_drop = !cmd_i.is_load && !active && (fill_q != '0);
  assign push    = res_fire || st_push_i;
  assign pop     = cmd_i.is_load ? pop_i : (req_fire || st_drop);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_q    <= '0;
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
      res_ptr_q <= '0;
      fill_q    <= '0;
      credit_q  <= '0;
    end else if (cmd_start_i) begin
      word_q    <= '0;
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
      res_ptr_q <= '0;
      fill_q    <= '0;
      credit_q  <= '0;
    end else begin
      if (req_fire) word_q <= word_q + 1'b1;
      if (ld_fire) res_ptr_q <= next_ptr(res_ptr_q);
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      fill_q   <= fill_q + cnt_t'(push) - cnt_t'(pop);
      credit_q <= credit_q + cnt_t'(ld_fire) - cnt_t'(res_fire);
    end
  end

  // Strobe is reserved at issue, the data fills the same entry later
  always_ff @(posedge clk_i) begin
    if (ld_fire) fifo_q[res_ptr_q].strb <= cur_strb;
    if (res_fire) fifo_q[wr_ptr_q].data <= x_mem_result_i;
    if (st_push_i) fifo_q[wr_ptr_q] <= '{data: st_data_i, strb: '1};
  end

  assign head_o       = fifo_q[rd_ptr_q];
  assign head_valid_o = cmd_i.is_load && (fill_q != '0);
  assign st_space_o   = 32'(fill_q) < FifoDepth;
  assign drained_o    = !active && (credit_q == '0) && (fill_q == '0);

endmodule

`default_nettype wire

//--- vlsu_issue.sv
/* Issue unit, one instruction in flight at a time
   Store reads are issued only while every lane can take a slot,
   and only one register file read is outstanding */

`timescale 1ns/1ps
`default_nettype none

module vlsu_issue #(
  parameter int unsigned NrPorts = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  vlsu_pkg::vlsu_req_t                 spatz_req_i,
  input  logic                                spatz_req_valid_i,
  output logic                                spatz_req_ready_o,
  output vlsu_pkg::vlsu_cmd_t                 cmd_o,
  output logic                                cmd_start_o,
  input  logic                  [NrPorts-1:0] lane_st_space_i,
  input  logic                  [NrPorts-1:0] lane_drained_i,
  input  logic                                wb_idle_i,
  output logic                                st_push_o,
  output vlsu_pkg::elen_t       [NrPorts-1:0] st_data_o,
  output logic                                vrf_re_o,
  output vlsu_pkg::vreg_addr_t                vrf_raddr_o,
  input  vlsu_pkg::elen_t       [NrPorts-1:0] vrf_rdata_i,
  input  logic                                vrf_rvalid_i,
  output logic                                vlsu_rsp_valid_o,
  output vlsu_pkg::vlsu_rsp_t                 vlsu_rsp_o,
  output logic                                x_mem_finished_o
);

  import vlsu_pkg::*;

  // Bytes covered by one register file word
  localparam int unsigned WordBytes = NrPorts * ELENB;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e    state_q, state_d;
  vlsu_cmd_t cmd_q;
  insn_id_t  id_q;
  vlen_t     req_bytes;
  vlen_t     nr_words;
  vlen_t     rd_word_q;
  logic      rd_pend_q;
  logic      accept;
  logic      reads_done;
  logic      finish;

  assign spatz_req_ready_o = (state_q == IDLE);
  assign accept            = spatz_req_valid_i && spatz_req_ready_o;
  assign cmd_start_o       = accept;
  assign cmd_o             = cmd_q;

  // vl in elements to vl in bytes
  always_comb begin
    unique case (spatz_req_i.vsew)
      EW_8:    req_bytes = spatz_req_i.vl;
      EW_16:   req_bytes = spatz_req_i.vl << 1;
      default: req_bytes = spatz_req_i.vl << 2;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_q <= '0;
      id_q  <= '0;
    end else if (accept) begin
      cmd_q.is_load <= spatz_req_i.is_load;
      cmd_q.vsew    <= spatz_req_i.vsew;
      cmd_q.bytes   <= req_bytes;
      cmd_q.base    <= spatz_req_i.rs1;
      cmd_q.vd      <= spatz_req_i.vd;
      id_q          <= spatz_req_i.id;
    end
  end

  ////////////////////
  // Store reads
  ////////////////////

  // Rounded up, a partial last word still needs a full read
  assign nr_words = vlen_t'((32'(cmd_q.bytes) + WordBytes - 1) / WordBytes);

  assign vrf_re_o = (state_q == RUN) && !cmd_q.is_load && !rd_pend_q &&
                    (rd_word_q < nr_words) && (&lane_st_space_i);
  assign vrf_raddr_o = (vreg_addr_t'(cmd_q.vd) << VregWordsLog2) + vreg_addr_t'(rd_word_q);

  // Returned word goes to all lanes in one push
  assign st_push_o  = vrf_rvalid_i && rd_pend_q;
  assign st_data_o  = vrf_rdata_i;
  assign reads_done = (rd_word_q == nr_words) && !rd_pend_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_word_q <= '0;
      rd_pend_q <= 1'b0;
    end else if (accept) begin
      rd_word_q <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      if (vrf_re_o) begin
        rd_word_q <= rd_word_q + 1'b1;
        rd_pend_q <= 1'b1;
      end else if (st_push_o) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Completion
  ////////////////////

  assign finish = (&lane_drained_i) && (cmd_q.is_load ? wb_idle_i : reads_done);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (accept) state_d = RUN;
      RUN:     if (finish) state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign vlsu_rsp_valid_o = (state_q == DONE);
  assign x_mem_finished_o = (state_q == DONE);
  assign vlsu_rsp_o.id    = id_q;
  assign vlsu_rsp_o.vd    = cmd_q.vd;

endmodule

`default_nettype wire

//--- vlsu_pkg.sv
/* Shared types for the vector load/store unit
   Slots are 32 bits wide, base addresses must be word aligned
   Only unit-stride accesses with vstart of zero are supported */

`default_nettype none

package vlsu_pkg;

  localparam int unsigned ELEN          = 32;
  localparam int unsigned ELENB         = ELEN / 8;
  localparam int unsigned VregWordsLog2 = 3;

  typedef logic [ELEN-1:0]  elen_t;
  typedef logic [ELENB-1:0] strb_t;
  typedef logic [31:0]      addr_t;
  typedef logic [7:0]       vreg_addr_t;
  typedef logic [15:0]      vlen_t;
  typedef logic [4:0]       vreg_id_t;
  typedef logic [2:0]       insn_id_t;

  // Element width, also the log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef struct packed {
    insn_id_t id;
    logic     is_load;
    vew_e     vsew;
    vlen_t    vl;
    vreg_id_t vd;
    addr_t    rs1;
  } vlsu_req_t;

  // Active command seen by the lanes, length already in bytes
  typedef struct packed {
    logic     is_load;
    vew_e     vsew;
    vlen_t    bytes;
    addr_t    base;
    vreg_id_t vd;
  } vlsu_cmd_t;

  typedef struct packed {
    insn_id_t id;
    vreg_id_t vd;
  } vlsu_rsp_t;

  typedef struct packed {
    addr_t      addr;
    logic       we;
    logic [1:0] size;
    strb_t      strb;
    elen_t      wdata;
    logic       last;
  } mem_req_t;

  typedef struct packed {
    elen_t data;
    strb_t strb;
  } lane_entry_t;

endpackage

`default_nettype wire
